/* Makefile */
# Verilator simulation of the PHOLD scheduling engine

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module phold_tb -f files.f -o phold_sim
	./obj_dir/phold_sim

clean:
	rm -rf obj_dir

/* design/event_queue.sv */
`timescale 1ns/1ps

module event_queue #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               enq,
   input  logic               deq,
   input  phold_pkg::event_t  in_event,
   output phold_pkg::event_t  head,
   output logic               empty,
   output logic               full
);

   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   phold_pkg::event_t      slots [QUEUE_DEPTH];   // slot 0 holds the smallest time
   logic [CNT_W-1:0]       count;
   logic [QUEUE_DEPTH-1:0] le;        // occupied slot with time not above the new one
   logic                   do_enq;
   logic                   do_deq;

   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(QUEUE_DEPTH));
   assign head    = slots[0];
   assign do_enq  = enq && !full;
   assign do_deq  = deq && !empty;

   // the array is sorted, so le is a run of ones from slot 0
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         le[i] = (i < int'(count)) && (slots[i].ts <= in_event.ts);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (do_enq) begin
         count <= count + 1'b1;
      end else if (do_deq) begin
         count <= count - 1'b1;
      end
   end

   // insert behind equal times, later entries move up one slot
   always_ff @(posedge clk) begin
      if (do_enq) begin
         if (!le[0]) slots[0] <= in_event;
         for (int i = 1; i < QUEUE_DEPTH; i++) begin
            if (!le[i]) begin
               if (le[i-1]) begin
                  slots[i] <= in_event;
               end else begin
                  slots[i] <= slots[i-1];
               end
            end
         end
      end else if (do_deq) begin
         for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            slots[i] <= slots[i+1];   // whole array drops by one
         end
      end
   end

endmodule

/* design/phold_core.sv */
`timescale 1ns/1ps

module phold_core #(
   parameter int CORE_ID = 0
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  take,        // dispatch edge for this core
   input  phold_pkg::event_t     cur_event,
   input  logic                  ack,
   output logic                  ready,
   output logic                  new_ready,
   output phold_pkg::event_t     out_event,
   output phold_pkg::core_time_t core_time
);

   // bit 0 forced high keeps the lfsr out of the all-zero state
   localparam logic [15:0] SEED = (16'hace1 + 16'(CORE_ID) * 16'h1f3b) | 16'h0001;
   localparam int NB_DELTA = $clog2(phold_pkg::MAX_DELTA);

   typedef enum logic [1:0] {
      C_READY,
      C_PROC,
      C_WAIT
   } core_state_e;

   core_state_e        state;
   logic [15:0]        lfsr;
   logic [15:0]        lfsr_next;
   logic [1:0]         delay_cnt;
   phold_pkg::time_t   held_ts;
   phold_pkg::time_t   incr;

   // x^16 + x^14 + x^13 + x^11
   assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

   // 1 .. MAX_DELTA
   assign incr = phold_pkg::time_t'(lfsr[6 +: NB_DELTA]) + phold_pkg::time_t'(1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= C_READY;
         lfsr      <= SEED;
         delay_cnt <= '0;
      end else begin
         case (state)
            C_READY: begin
               if (take) begin
                  state     <= C_PROC;
                  delay_cnt <= lfsr[1:0];   // 1 to 4 cycles of work
                  lfsr      <= lfsr_next;
               end
            end
            C_PROC: begin
               if (delay_cnt == '0) begin
                  state <= C_WAIT;
               end else begin
                  delay_cnt <= delay_cnt - 1'b1;
               end
            end
            C_WAIT: begin
               if (ack) state <= C_READY;   // else the queue is full, keep holding
            end
            default: state <= C_READY;
         endcase
      end
   end

   // draws taken from the lfsr value seen at the dispatch edge
   always_ff @(posedge clk) begin
      if (take && state == C_READY) begin
         held_ts      <= cur_event.ts;
         out_event.lp <= lfsr[5:2];
         out_event.ts <= cur_event.ts + incr;
      end
   end

   assign ready          = (state == C_READY);
   assign new_ready      = (state == C_WAIT);
   assign core_time.busy = (state != C_READY);
   assign core_time.ts   = held_ts;

endmodule

/* design/phold_pkg.sv */
package phold_pkg;

   // timestamps and logical processes
   localparam int TIME_WID  = 16;
   localparam int NUM_LP    = 16;
   localparam int NB_LPID   = 4;
   localparam int MAX_DELTA = 8;   // largest increment a core adds to a timestamp

   typedef logic [TIME_WID-1:0] time_t;
   typedef logic [NB_LPID-1:0]  lp_id_t;

   // event message between queue, cores and outside, lp in the upper bits
   typedef struct packed {
      lp_id_t lp;
      time_t  ts;
   } event_t;

   // what a core reports towards the gvt minimum
   typedef struct packed {
      logic  busy;
      time_t ts;
   } core_time_t;

   // observation of the event leaving the queue
   typedef struct packed {
      logic   vld;
      event_t ev;
   } dispatch_t;

   typedef enum logic [2:0] {
      IDLE,
      INIT,
      READY,
      RUNNING,
      FINISHED
   } run_state_e;

endpackage

/* design/phold_top.sv */
`timescale 1ns/1ps

module phold_top #(
   parameter int NUM_CORE    = 4,
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 start,
   input  phold_pkg::time_t     end_time,
   output phold_pkg::time_t     gvt,
   output logic                 done,
   output phold_pkg::dispatch_t dispatch
);

   localparam int IDX_W = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

   logic                                 enq;
   logic                                 deq;
   logic                                 q_empty;
   logic                                 q_full;
   phold_pkg::event_t                    q_head;
   phold_pkg::event_t                    enq_event;
   phold_pkg::event_t                    rcv_event;
   logic [NUM_CORE-1:0]                  ack;
   logic [NUM_CORE-1:0]                  core_ready;
   logic [NUM_CORE-1:0]                  core_new;
   phold_pkg::event_t    [NUM_CORE-1:0]  core_out;
   phold_pkg::core_time_t [NUM_CORE-1:0] core_time;
   logic [NUM_CORE-1:0]                  send_gnt;
   logic [NUM_CORE-1:0]                  rcv_gnt;
   logic [IDX_W-1:0]                     rcv_idx;
   logic                                 any_ready;
   logic                                 any_new;

   assign rcv_event = core_out[rcv_idx];   // event of the core being collected
   assign dispatch  = '{vld: deq, ev: q_head};

   run_control #(.NUM_CORE(NUM_CORE)) u_run_control (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .end_time  (end_time),
      .q_empty   (q_empty),
      .q_full    (q_full),
      .head      (q_head),
      .core_time (core_time),
      .any_ready (any_ready),
      .any_new   (any_new),
      .rcv_gnt   (rcv_gnt),
      .rcv_event (rcv_event),
      .enq       (enq),
      .deq       (deq),
      .enq_event (enq_event),
      .ack       (ack),
      .gvt       (gvt),
      .done      (done)
   );

   event_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_event_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .deq      (deq),
      .in_event (enq_event),
      .head     (q_head),
      .empty    (q_empty),
      .full     (q_full)
   );

   // dispatch to ready cores, the one-hot grant is all the cores need
   rr_arbiter #(.NUM_CORE(NUM_CORE)) send_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_ready),
      .adv     (deq),
      .gnt     (send_gnt),
      .gnt_idx (),
      .any     (any_ready)
   );

   // collect finished events, pointer moves only on an accepted result
   rr_arbiter #(.NUM_CORE(NUM_CORE)) rcv_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_new),
      .adv     (|ack),
      .gnt     (rcv_gnt),
      .gnt_idx (rcv_idx),
      .any     (any_new)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : gen_core
      phold_core #(.CORE_ID(g)) u_core (
         .clk       (clk),
         .rst_n     (rst_n),
         .take      (send_gnt[g] & deq),
         .cur_event (q_head),        // head fans out to every core
         .ack       (ack[g]),
         .ready     (core_ready[g]),
         .new_ready (core_new[g]),
         .out_event (core_out[g]),
         .core_time (core_time[g])
      );
   end

endmodule

/* design/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter #(
   parameter int NUM_CORE = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [NUM_CORE-1:0] req,
   input  logic                adv,      // grant was used this cycle
   output logic [NUM_CORE-1:0] gnt,
   output logic [((NUM_CORE > 1) ? $clog2(NUM_CORE) : 1)-1:0] gnt_idx,
   output logic                any
);

   localparam int IDX_W = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

   logic [IDX_W-1:0] last;   // last served position

   // first requester after the last served one, wrapping around
   always_comb begin
      int pos;
      gnt     = '0;
      gnt_idx = '0;
      any     = 1'b0;
      for (int i = 1; i <= NUM_CORE; i++) begin
         pos = (int'(last) + i) % NUM_CORE;
         if (!any && req[pos]) begin
            any      = 1'b1;
            gnt[pos] = 1'b1;
            gnt_idx  = IDX_W'(pos);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last <= IDX_W'(NUM_CORE - 1);   // so core 0 wins first
      end else if (adv && any) begin
         last <= gnt_idx;
      end
   end

endmodule

/* design/run_control.sv */
`timescale 1ns/1ps

module run_control #(
   parameter int NUM_CORE = 4
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 start,
   input  phold_pkg::time_t                     end_time,
   input  logic                                 q_empty,
   input  logic                                 q_full,
   input  phold_pkg::event_t                    head,
   input  phold_pkg::core_time_t [NUM_CORE-1:0] core_time,
   input  logic                                 any_ready,
   input  logic                                 any_new,
   input  logic [NUM_CORE-1:0]                  rcv_gnt,
   input  phold_pkg::event_t                    rcv_event,
   output logic                                 enq,
   output logic                                 deq,
   output phold_pkg::event_t                    enq_event,
   output logic [NUM_CORE-1:0]                  ack,
   output phold_pkg::time_t                     gvt,
   output logic                                 done
);

   phold_pkg::run_state_e  state;
   phold_pkg::run_state_e  state_next;
   phold_pkg::lp_id_t      init_cnt;   // lp seeded this cycle
   logic                   init_last;
   logic                   run_enq;    // core result accepted into the queue
   logic                   min_vld;
   phold_pkg::time_t       min_ts;

   assign init_last = (init_cnt == phold_pkg::lp_id_t'(phold_pkg::NUM_LP - 1));

   always_comb begin
      state_next = state;
      case (state)
         phold_pkg::IDLE:     if (start) state_next = phold_pkg::INIT;
         phold_pkg::INIT:     if (init_last) state_next = phold_pkg::READY;
         phold_pkg::READY:    state_next = phold_pkg::RUNNING;
         phold_pkg::RUNNING:  if (gvt > end_time) state_next = phold_pkg::FINISHED;
         phold_pkg::FINISHED: state_next = phold_pkg::IDLE;
         default:             state_next = phold_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= phold_pkg::IDLE;
         init_cnt <= '0;
      end else begin
         state    <= state_next;
         init_cnt <= (state == phold_pkg::INIT) ? init_cnt + 1'b1 : '0;
      end
   end

   // enqueue wins over dispatch
   assign run_enq   = (state == phold_pkg::RUNNING) && any_new && !q_full;
   assign enq       = (state == phold_pkg::INIT) || run_enq;
   assign deq       = (state == phold_pkg::RUNNING) && !enq && !q_empty && any_ready;
   assign ack       = rcv_gnt & {NUM_CORE{run_enq}};
   assign enq_event = (state == phold_pkg::INIT) ?
                      phold_pkg::event_t'{lp: init_cnt, ts: '0} : rcv_event;
   assign done      = (state == phold_pkg::FINISHED);

   // smallest of the queue head and every held event
   always_comb begin
      min_vld = !q_empty;
      min_ts  = head.ts;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (core_time[i].busy && (!min_vld || core_time[i].ts < min_ts)) begin
            min_vld = 1'b1;
            min_ts  = core_time[i].ts;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (state == phold_pkg::RUNNING && min_vld) begin
         gvt <= min_ts;   // held outside running
      end
   end

endmodule

/* files.f */
design/phold_pkg.sv
design/rr_arbiter.sv
design/event_queue.sv
design/phold_core.sv
design/run_control.sv
design/phold_top.sv
tests/phold_tb.sv

/* tests/phold_tb.sv */
`timescale 1ns/1ps

module phold_tb;

   localparam int NUM_CORE    = 4;
   localparam int QUEUE_DEPTH = 16;
   localparam int NUM_ROWS    = 5;
   localparam int HOLD_CYCLES = 8;   // cycles watched after done

   // one run of the engine
   typedef struct packed {
      phold_pkg::time_t end_time;
      logic [7:0]       first_cnt;   // leading dispatches that carry seeded events
   } row_t;

   logic                 clk;
   logic                 rst_n;
   logic                 start;
   phold_pkg::time_t     end_time;
   phold_pkg::time_t     gvt;
   logic                 done;
   phold_pkg::dispatch_t dispatch;

   int unsigned          cycles;
   int unsigned          limit;

   row_t rows [NUM_ROWS] = '{
      '{16'd0,    8'(NUM_CORE)},
      '{16'd5,    8'(NUM_CORE)},
      '{16'd40,   8'(NUM_CORE)},
      '{16'd200,  8'(NUM_CORE)},
      '{16'd1000, 8'(NUM_CORE)}
   };

   phold_top #(
      .NUM_CORE    (NUM_CORE),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) uut (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .end_time (end_time),
      .gvt      (gvt),
      .done     (done),
      .dispatch (dispatch)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // run length budget grows with each target time
   initial begin
      limit = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         limit += 64 * (int'(rows[r].end_time) + phold_pkg::MAX_DELTA) + 100;
      end
      cycles = 0;
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Test failed");
      $fatal(1, "timeout, the runs did not finish within %0d cycles", limit);
   end

   task automatic check_time(input string name, input phold_pkg::time_t got,
                             input phold_pkg::time_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic check_event(input string name, input phold_pkg::event_t got,
                              input phold_pkg::event_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got lp %0d ts %0d, expected lp %0d ts %0d",
                  $time, name, got.lp, got.ts, exp.lp, exp.ts);
         $display("Test failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic run_row(input row_t row);
      int unsigned       gap;
      int unsigned       n_disp;
      phold_pkg::time_t  prev1;
      phold_pkg::time_t  prev2;
      phold_pkg::time_t  hold;
      phold_pkg::event_t exp_ev;
      logic              seen_done;

      // reset with the target time already in place
      @(negedge clk);
      rst_n    = 1'b0;
      start    = 1'b0;
      end_time = row.end_time;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      gap = ($urandom % 8) + 1;
      repeat (gap) begin
         @(negedge clk);
         check_time("gvt", gvt, '0);
         check_bit("done", done, 1'b0);
         check_bit("dispatch.vld", dispatch.vld, 1'b0);
      end
      start = 1'b1;

      // init seeds one event per lp, then one ready cycle
      for (int i = 0; i <= phold_pkg::NUM_LP; i++) begin
         @(negedge clk);
         start = 1'b0;
         check_bit("dispatch.vld", dispatch.vld, 1'b0);
         check_bit("done", done, 1'b0);
         check_time("gvt", gvt, '0);
      end

      n_disp    = 0;
      prev1     = gvt;
      prev2     = gvt;
      seen_done = 1'b0;
      while (!seen_done) begin
         @(negedge clk);
         check_bit($sformatf("gvt %0d not below previous %0d", gvt, prev1),
                   gvt >= prev1, 1'b1);
         if (dispatch.vld) begin
            check_bit($sformatf("dispatch.ev.ts %0d not below gvt %0d", dispatch.ev.ts, gvt),
                      dispatch.ev.ts >= gvt, 1'b1);
            if (n_disp < row.first_cnt) begin
               // seeded in lp order at time zero, equal times keep arrival order
               exp_ev.lp = phold_pkg::lp_id_t'(n_disp);
               exp_ev.ts = '0;
               check_event("dispatch.ev", dispatch.ev, exp_ev);
            end
            n_disp++;
         end
         if (done) begin
            seen_done = 1'b1;
            check_bit($sformatf("gvt %0d above end_time %0d", gvt, row.end_time),
                      gvt > row.end_time, 1'b1);
            check_bit($sformatf("gvt %0d before last running cycle within end_time", prev2),
                      prev2 <= row.end_time, 1'b1);
            check_bit("seeded dispatches seen before done", n_disp >= row.first_cnt, 1'b1);
         end
         prev2 = prev1;
         prev1 = gvt;
      end

      // done lasts one cycle, afterwards the engine sits still
      hold = gvt;
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         check_bit("done", done, 1'b0);
         check_bit("dispatch.vld", dispatch.vld, 1'b0);
         check_time("gvt", gvt, hold);
      end
   endtask

   initial begin
      void'($urandom(32'h8608_e439));
      rst_n    = 1'b0;
      start    = 1'b0;
      end_time = '0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(rows[r]);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule
